//--- rtl/vid_pkg.sv
package vid_pkg;

    // ============================================================
    // pixel and sync types
    // ============================================================

    typedef logic [23:0] rgb_t;     // r in [23:16], b in [7:0]

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } sync_t;                       // all active high

    // ============================================================
    // overlay
    // ============================================================

    typedef enum logic [1:0] {
        OSD_BLACK  = 2'd0,
        OSD_BLUE   = 2'd1,
        OSD_YELLOW = 2'd2,
        OSD_WHITE  = 2'd3
    } osd_color_e;

    // indexed by osd_color_e
    localparam rgb_t OSD_RGB [4] = '{24'h000000, 24'h0000ff, 24'hffff00, 24'hffffff};

    typedef struct packed {
        rgb_t       rgb;
        sync_t      sync;
        logic       osd_en;
        osd_color_e osd_color;
    } pix_in_t;

    typedef struct packed {
        rgb_t  rgb;
        sync_t sync;
    } pix_out_t;

    // two slots per word, like the par-by-2 video path
    localparam int DEFAULT_LANES = 2;

endpackage

//--- rtl/lane_bus_if.sv
`timescale 1ns/1ps

// one element per lane, valid/ready per element
interface lane_bus_if #(
    parameter type PIX_T     = logic,
    parameter int  NUM_LANES = 2
);

    logic [NUM_LANES-1:0] valid;
    logic [NUM_LANES-1:0] ready;
    PIX_T                 pix [NUM_LANES];
    logic [NUM_LANES-1:0] first;    // frame start mark

    modport src (
        output valid,
        output pix,
        output first,
        input  ready
    );

    modport dst (
        input  valid,
        input  pix,
        input  first,
        output ready
    );

endinterface

//--- rtl/pixel_packer.sv
`timescale 1ns/1ps

module pixel_packer #(
    parameter int NUM_LANES = 2
) (
    input  logic             clk27,
    input  logic             sys_reset_n,
    input  logic             in_valid_i,
    output logic             in_ready_o,
    input  vid_pkg::pix_in_t in_pix_i,
    lane_bus_if.src          bus_o
);

    import vid_pkg::*;

    localparam int CW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [CW-1:0]        cnt_q;        // next free slot
    logic [NUM_LANES-1:0] valid_q;
    logic                 vs_prev_q;    // vsync of previous accepted pixel
    pix_in_t              slot_q [NUM_LANES];
    logic [NUM_LANES-1:0] first_q;
    logic                 accept;
    logic                 last_slot;
    logic                 frame_mark;

    // high when no element is left waiting after this clock
    assign in_ready_o = &(~valid_q | bus_o.ready);
    assign accept     = in_valid_i & in_ready_o;
    assign last_slot  = (cnt_q == CW'(NUM_LANES - 1));

    // vsync falling edge while hsync low
    assign frame_mark = vs_prev_q & ~in_pix_i.sync.vsync & ~in_pix_i.sync.hsync;

    assign bus_o.valid = valid_q;
    assign bus_o.pix   = slot_q;
    assign bus_o.first = first_q;

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            cnt_q     <= '0;
            valid_q   <= '0;
            vs_prev_q <= 1'b0;
        end else begin
            valid_q <= valid_q & ~bus_o.ready;  // lanes retire their element
            if (accept) begin
                vs_prev_q <= in_pix_i.sync.vsync;
                if (last_slot) begin
                    cnt_q   <= '0;
                    valid_q <= '1;              // word out next cycle
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    // slot payload
    always_ff @(posedge clk27) begin
        if (accept) begin
            slot_q[cnt_q]  <= in_pix_i;
            first_q[cnt_q] <= frame_mark;
        end
    end

    // lanes take a word together, so no lane may run ahead of the others
    a_valid_lockstep: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        (valid_q == '0) || (valid_q == '1)
    );

endmodule

//--- rtl/osd_lane.sv
`timescale 1ns/1ps

module osd_lane #(
    parameter int LANE = 0
) (
    input  logic    clk27,
    input  logic    sys_reset_n,
    lane_bus_if.dst bus_i,
    lane_bus_if.src bus_o
);

    import vid_pkg::*;

    pix_in_t  in_pix;
    pix_out_t pix_d;
    pix_out_t pix_q;
    logic     first_q;
    logic     valid_q;
    logic     lane_ready;
    logic     accept;

    assign in_pix = bus_i.pix[LANE];

    // empty, or the held pixel leaves this cycle
    assign lane_ready = ~valid_q | bus_o.ready[LANE];
    assign accept     = bus_i.valid[LANE] & lane_ready;

    assign bus_i.ready[LANE] = lane_ready;

    // overlay replaces the colour, sync passes through
    always_comb begin
        pix_d.sync = in_pix.sync;
        if (in_pix.osd_en) begin
            pix_d.rgb = OSD_RGB[in_pix.osd_color];
        end else begin
            pix_d.rgb = in_pix.rgb;
        end
    end

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (bus_o.ready[LANE]) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk27) begin
        if (accept) begin
            pix_q   <= pix_d;
            first_q <= bus_i.first[LANE];
        end
    end

    assign bus_o.valid[LANE] = valid_q;
    assign bus_o.pix[LANE]   = pix_q;
    assign bus_o.first[LANE] = first_q;

    // offered pixel must not move until this lane takes it
    a_in_hold: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        bus_i.valid[LANE] && !lane_ready |=> bus_i.valid[LANE]
            && $stable(bus_i.pix[LANE]) && $stable(bus_i.first[LANE])
    );

endmodule

//--- rtl/pixel_unpacker.sv
`timescale 1ns/1ps

module pixel_unpacker #(
    parameter int NUM_LANES = 2
) (
    input  logic              clk27,
    input  logic              sys_reset_n,
    lane_bus_if.dst           bus_i,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output vid_pkg::pix_out_t out_pix_o,
    output logic              frame_start_o
);

    import vid_pkg::*;

    localparam int CW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [CW-1:0] idx_q;           // slot being serialized
    logic          out_valid_q;
    logic          frame_q;
    pix_out_t      pix_q;
    logic          all_valid;
    logic          load;
    logic          take;
    logic          last_slot;

    assign all_valid = &bus_i.valid;
    assign load      = ~out_valid_q | out_ready_i;    // output register free
    assign take      = all_valid & load;
    assign last_slot = (idx_q == CW'(NUM_LANES - 1));

    // release the whole word with its last slot
    assign bus_i.ready = {NUM_LANES{take & last_slot}};

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            idx_q       <= '0;
            out_valid_q <= 1'b0;
            frame_q     <= 1'b0;
        end else if (take) begin
            out_valid_q <= 1'b1;
            frame_q     <= bus_i.first[idx_q];
            if (last_slot) begin
                idx_q <= '0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;    // drained, nothing new
            frame_q     <= 1'b0;
        end
    end

    always_ff @(posedge clk27) begin
        if (take) begin
            pix_q <= bus_i.pix[idx_q];
        end
    end

    assign out_valid_o   = out_valid_q;
    assign out_pix_o     = pix_q;
    assign frame_start_o = frame_q;

    // lanes are loaded together, so they must present together
    a_lanes_aligned: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        (bus_i.valid == '0) || (bus_i.valid == '1)
    );

endmodule

//--- rtl/vid_pair_top.sv
`timescale 1ns/1ps

module vid_pair_top #(
    parameter int NUM_LANES = vid_pkg::DEFAULT_LANES
) (
    input  logic                clk27,
    input  logic                sys_reset_n,
    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  vid_pkg::rgb_t       in_rgb_i,
    input  logic                in_hsync_i,
    input  logic                in_vsync_i,
    input  logic                in_de_i,
    input  logic                osd_en_i,
    input  vid_pkg::osd_color_e osd_color_i,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output vid_pkg::rgb_t       out_rgb_o,
    output logic                out_hsync_o,
    output logic                out_vsync_o,
    output logic                out_de_o,
    output logic                frame_start_o
);

    import vid_pkg::*;

    pix_in_t  in_pix;
    pix_out_t out_pix;

    assign in_pix = '{rgb: in_rgb_i,
                      sync: '{hsync: in_hsync_i, vsync: in_vsync_i, de: in_de_i},
                      osd_en: osd_en_i,
                      osd_color: osd_color_i};

    assign out_rgb_o   = out_pix.rgb;
    assign out_hsync_o = out_pix.sync.hsync;
    assign out_vsync_o = out_pix.sync.vsync;
    assign out_de_o    = out_pix.sync.de;

    // ============================================================
    // packer -> lanes -> unpacker
    // ============================================================

    lane_bus_if #(.PIX_T(pix_in_t), .NUM_LANES(NUM_LANES)) in_bus ();
    lane_bus_if #(.PIX_T(pix_out_t), .NUM_LANES(NUM_LANES)) out_bus ();

    pixel_packer #(.NUM_LANES(NUM_LANES)) u_packer (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_pix_i    (in_pix),
        .bus_o       (in_bus.src)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        osd_lane #(.LANE(i)) u_lane (
            .clk27       (clk27),
            .sys_reset_n (sys_reset_n),
            .bus_i       (in_bus.dst),
            .bus_o       (out_bus.src)
        );
    end

    pixel_unpacker #(.NUM_LANES(NUM_LANES)) u_unpacker (
        .clk27         (clk27),
        .sys_reset_n   (sys_reset_n),
        .bus_i         (out_bus.dst),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .out_pix_o     (out_pix),
        .frame_start_o (frame_start_o)
    );

endmodule

//--- verif/tb_vid_pair.sv
`timescale 1ns/1ps

module tb_vid_pair;

    import vid_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_PIX      = 400;
    localparam int LINE_LEN     = 8;    // pixels per synthetic line
    localparam int FRAME_LINES  = 4;    // lines 0 and 2 carry vsync
    localparam int STALL_CYCLES = 24;

    typedef struct packed {
        rgb_t rgb;
        logic hs;
        logic vs;
        logic de;
        logic frame;
    } exp_t;

    logic       clk27;
    logic       sys_reset_n;
    logic       in_valid_i;
    logic       in_ready_o;
    rgb_t       in_rgb_i;
    logic       in_hsync_i;
    logic       in_vsync_i;
    logic       in_de_i;
    logic       osd_en_i;
    osd_color_e osd_color_i;
    logic       out_valid_o;
    logic       out_ready_i;
    rgb_t       out_rgb_o;
    logic       out_hsync_o;
    logic       out_vsync_o;
    logic       out_de_o;
    logic       frame_start_o;

    exp_t exp_q [$];    // accepted pixels, oldest first
    int   hpos;
    int   vline;

    vid_pair_top uut (.*);

    initial begin
        clk27 = 1'b0;
        forever #(CLK_PERIOD / 2) clk27 = ~clk27;
    end

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_field(string name, logic [23:0] got, logic [23:0] want);
        assert (got === want) else begin
            $display("mismatch %s: got %h expected %h", name, got, want);
            stop_on_error();
        end
    endtask

    // overlay colours by enum order
    function automatic rgb_t overlay_rgb(osd_color_e c);
        case (c)
            OSD_BLACK:  return 24'h000000;
            OSD_BLUE:   return 24'h0000ff;
            OSD_YELLOW: return 24'hffff00;
            default:    return 24'hffffff;
        endcase
    endfunction

    // next pixel of the raster, hsync at line end
    // vsync falls with hsync low after line 0, and with hsync high at the end of line 2
    task automatic next_pixel();
        in_rgb_i    = 24'($urandom);
        osd_en_i    = ($urandom_range(3) == 0);
        osd_color_i = osd_color_e'(2'($urandom_range(3)));
        in_hsync_i  = (hpos >= LINE_LEN - 2);
        in_vsync_i  = (vline == 0) || (vline == 2 && hpos < LINE_LEN - 1);
        in_de_i     = !in_hsync_i && !in_vsync_i;
        if (hpos == LINE_LEN - 1) begin
            hpos  = 0;
            vline = (vline == FRAME_LINES - 1) ? 0 : vline + 1;
        end else begin
            hpos = hpos + 1;
        end
    endtask

    // ============================================================
    // output protocol checks
    // ============================================================

    a_out_hold: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_rgb_o)
            && $stable(out_hsync_o) && $stable(out_vsync_o) && $stable(out_de_o)
            && $stable(frame_start_o)
    ) else begin
        $display("output pixel changed while out_ready_i was low");
        stop_on_error();
    end

    a_frame_idle: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        !out_valid_o |-> !frame_start_o
    ) else begin
        $display("frame_start_o high without a valid output pixel");
        stop_on_error();
    end

    // ============================================================
    // stimulus and reference queue
    // ============================================================

    initial begin : stimulus
        int          sent_cnt;
        int          recv_cnt;
        int          stall_left;
        logic        hold;
        logic        advance;
        logic        stalled;
        logic        ready_dropped;
        logic        vs_prev;
        logic [3:0]  colors_seen;
        exp_t        e;

        void'($urandom(32'h03530831));
        sys_reset_n   = 1'b0;
        in_valid_i    = 1'b0;
        out_ready_i   = 1'b0;
        in_rgb_i      = '0;
        in_hsync_i    = 1'b0;
        in_vsync_i    = 1'b0;
        in_de_i       = 1'b0;
        osd_en_i      = 1'b0;
        osd_color_i   = OSD_BLACK;
        hpos          = 0;
        vline         = 0;
        sent_cnt      = 0;
        recv_cnt      = 0;
        stall_left    = 0;
        hold          = 1'b0;
        advance       = 1'b0;
        stalled       = 1'b0;
        ready_dropped = 1'b0;
        vs_prev       = 1'b0;
        colors_seen   = '0;

        repeat (RESET_CYCLES) @(negedge clk27);
        sys_reset_n = 1'b1;
        #1;
        assert (!out_valid_o && !frame_start_o && in_ready_o) else begin
            $display("handshake outputs wrong after reset");
            stop_on_error();
        end
        next_pixel();

        while (recv_cnt < NUM_PIX) begin
            @(negedge clk27);
            if (advance) begin
                next_pixel();
            end
            if (!stalled && sent_cnt >= NUM_PIX / 2) begin
                stalled    = 1'b1;
                stall_left = STALL_CYCLES;
            end
            if (!hold) begin  // valid may only drop after a transfer
                in_valid_i = (sent_cnt < NUM_PIX) &&
                             (stall_left > 0 || $urandom_range(3) != 0);
            end
            if (stall_left > 0) begin
                out_ready_i = 1'b0;
                stall_left  = stall_left - 1;
            end else begin
                out_ready_i = ($urandom_range(3) != 0);
            end

            #1;  // settle, then see what transfers at the next rising edge
            if (stall_left > 0 && !in_ready_o) begin
                ready_dropped = 1'b1;
            end
            advance = in_valid_i && in_ready_o;
            hold    = in_valid_i && !in_ready_o;
            if (advance) begin
                e.rgb   = osd_en_i ? overlay_rgb(osd_color_i) : in_rgb_i;
                e.hs    = in_hsync_i;
                e.vs    = in_vsync_i;
                e.de    = in_de_i;
                e.frame = vs_prev && !in_vsync_i && !in_hsync_i;
                vs_prev = in_vsync_i;
                if (osd_en_i) begin
                    colors_seen[osd_color_i] = 1'b1;
                end
                exp_q.push_back(e);
                sent_cnt = sent_cnt + 1;
            end
            if (out_valid_o && out_ready_i) begin
                assert (exp_q.size() > 0) else begin
                    $display("output pixel with no accepted input behind it");
                    stop_on_error();
                end
                e = exp_q.pop_front();
                compare_field("out_rgb_o", out_rgb_o, e.rgb);
                compare_field("out_hsync_o", 24'(out_hsync_o), 24'(e.hs));
                compare_field("out_vsync_o", 24'(out_vsync_o), 24'(e.vs));
                compare_field("out_de_o", 24'(out_de_o), 24'(e.de));
                compare_field("frame_start_o", 24'(frame_start_o), 24'(e.frame));
                recv_cnt = recv_cnt + 1;
            end
        end

        if (!ready_dropped) begin
            $display("in_ready_o never dropped while the output was stalled");
            stop_on_error();
        end else if (colors_seen != 4'hf) begin
            $display("not every overlay colour was driven");
            stop_on_error();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    // watchdog
    initial begin
        #((NUM_PIX * 20 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: output stream did not drain in time");
        stop_on_error();
    end

endmodule

//--- filelist.f
rtl/vid_pkg.sv
rtl/lane_bus_if.sv
rtl/pixel_packer.sv
rtl/osd_lane.sv
rtl/pixel_unpacker.sv
rtl/vid_pair_top.sv
verif/tb_vid_pair.sv

//--- run_sim.sh
#!/bin/sh
# build and run the video pair testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_vid_pair \
    -o sim_vid_pair

out=$(./obj_dir/sim_vid_pair 2>&1) || true
echo "$out"

if echo "$out" | grep -q "NO ERRORS"; then
    exit 0
fi
exit 1
